/* apb_regs.sv */
`timescale 1ns/1ps

`include "fb_consts.svh"

module apb_regs (
  input  logic                   clk_in,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`PADDR_BITS-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   enable,
  output pixel_pkg::color_t      pattern,
  input  logic                   new_frame,
  output logic                   host_req,
  output pixel_pkg::pix_addr_t   host_addr,
  input  logic                   host_gnt,
  input  pixel_pkg::color_t      rd_data
);

  bus_pkg::reg_sel_t    sel;
  pixel_pkg::pix_addr_t pix_addr;
  logic [15:0]          frames;
  logic                 capture; // rd_data is valid this cycle
  logic                 setup;
  logic                 done;

  assign pix_addr = paddr[`PIX_WINDOW_BIT-1:2];
  assign setup    = psel && !penable;
  assign done     = psel && penable && pready;

  always_comb begin
    if (paddr[`PIX_WINDOW_BIT]) begin
      // Indices past the last pixel fall through as unmapped
      if (pix_addr < pixel_pkg::pix_addr_t'(`DISPLAY_WIDTH * `DISPLAY_HEIGHT)) begin
        sel = bus_pkg::PIXEL;
      end else begin
        sel = bus_pkg::NONE;
      end
    end else begin
      case (paddr)
        `REG_CTRL:    sel = bus_pkg::CTRL;
        `REG_PATTERN: sel = bus_pkg::PATTERN;
        `REG_FRAMES:  sel = bus_pkg::FRAMES;
        default:      sel = bus_pkg::NONE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      pready   <= 1'b0;
      pslverr  <= 1'b0;
      host_req <= 1'b0;
      capture  <= 1'b0;
      enable   <= 1'b0;
      pattern  <= '0;
      frames   <= '0;
    end else begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
      if (new_frame) frames <= frames + 1'b1;
      if (setup) begin
        case (sel)
          bus_pkg::CTRL, bus_pkg::PATTERN, bus_pkg::FRAMES: pready <= 1'b1;
          bus_pkg::PIXEL: begin
            if (pwrite) begin
              pready  <= 1'b1;
              pslverr <= 1'b1; // Pixel window is read only
            end else begin
              host_req <= 1'b1;
            end
          end
          default: begin
            pready  <= 1'b1;
            pslverr <= 1'b1;
          end
        endcase
      end
      if (host_req && host_gnt) begin
        host_req <= 1'b0;
        capture  <= 1'b1;
      end
      if (capture) begin
        capture <= 1'b0;
        pready  <= 1'b1;
      end
      // Register writes commit in the completing access cycle
      if (done && pwrite && sel == bus_pkg::CTRL) enable <= pwdata[0];
      if (done && pwrite && sel == bus_pkg::PATTERN) pattern <= pwdata[3:0];
    end
  end

  always_ff @(posedge clk_in) begin
    if (setup) begin
      host_addr <= pix_addr;
      case (sel)
        bus_pkg::CTRL:    prdata <= {31'b0, enable};
        bus_pkg::PATTERN: prdata <= {28'b0, pattern};
        bus_pkg::FRAMES:  prdata <= {16'b0, frames};
        default:          prdata <= '0;
      endcase
    end else if (capture) begin
      prdata <= {28'b0, rd_data};
    end
  end

endmodule

/* bus_pkg.sv */
package bus_pkg;

  // Target of an APB access after address decode
  typedef enum logic [2:0] {
    CTRL,
    PATTERN,
    FRAMES,
    PIXEL,
    NONE
  } reg_sel_t;

  // Owner of the front-bank read port in a given cycle
  typedef enum logic {
    SCAN,
    HOST
  } requester_t;

endpackage

/* fb_assert.sv */
`timescale 1ns/1ps

`include "fb_consts.svh"

module fb_assert (
  input logic clk_in,
  input logic rst_n,
  input logic host_req,
  input logic host_gnt,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pix_active,
  input logic hsync,
  input logic vsync
);

  int unsigned fails = 0; // Number of failed assertions
  int unsigned host_wait; // Cycles the pending host read has waited for the port

  always_ff @(posedge clk_in) begin
    if (!rst_n || !host_req || host_gnt) begin
      host_wait <= 0;
    end else begin
      host_wait <= host_wait + 1;
    end
  end

  // Scan-out holds the read port for at most one line of active cycles
  host_grant_latency: assert property (@(posedge clk_in) disable iff (!rst_n)
    host_req |-> host_wait <= `DISPLAY_WIDTH)
    else begin
      fails++;
      $error("Host read waited longer than one line of active cycles for the read port");
    end

  pready_in_access: assert property (@(posedge clk_in) disable iff (!rst_n)
    pready |-> psel && penable)
    else begin
      fails++;
      $error("pready was high outside an APB access phase");
    end

  // Sync is active low
  no_active_in_sync: assert property (@(posedge clk_in) disable iff (!rst_n)
    pix_active |-> hsync && vsync)
    else begin
      fails++;
      $error("pix_active was high during a sync pulse");
    end

  hsync_width: assert property (@(posedge clk_in) disable iff (!rst_n)
    $fell(hsync) |-> !hsync ##1 !hsync ##1 !hsync ##1 !hsync ##1 hsync)
    else begin
      fails++;
      $error("hsync low pulse did not last 4 clocks");
    end

endmodule

bind fb_top fb_assert u_fb_assert (
  .clk_in     (clk_in),
  .rst_n      (rst_n),
  .host_req   (host_req),
  .host_gnt   (host_gnt),
  .psel       (psel),
  .penable    (penable),
  .pready     (pready),
  .pix_active (pix_active),
  .hsync      (hsync),
  .vsync      (vsync)
);

/* fb_consts.svh */
`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// Raster geometry in pixel clocks and lines
`define DISPLAY_WIDTH 32
`define DISPLAY_HEIGHT 24
`define H_TOTAL 40
`define V_TOTAL 28

// Sync windows, both ends inclusive
`define H_SYNC_START 34
`define H_SYNC_END 37
`define V_SYNC_START 25
`define V_SYNC_END 26

`define H_BITS 6
`define V_BITS 5
`define ADDR_BITS 10
`define PADDR_BITS 13

`define REG_CTRL 13'h000
`define REG_PATTERN 13'h004
`define REG_FRAMES 13'h008
`define PIX_WINDOW_BIT 12 // Pixel index sits in paddr[11:2] below this bit

`endif

/* fb_manager.sv */
`timescale 1ns/1ps

`include "fb_consts.svh"

module fb_manager (
  input  logic                 clk_in,
  input  logic                 rst_n,
  input  logic                 new_frame,
  input  logic                 wr_en,
  input  pixel_pkg::pix_addr_t wr_addr,
  input  pixel_pkg::color_t    wr_color,
  input  logic                 rd_en,
  input  pixel_pkg::pix_addr_t rd_addr,
  output pixel_pkg::color_t    rd_data
);

  localparam int unsigned DEPTH = `DISPLAY_WIDTH * `DISPLAY_HEIGHT;

  pixel_pkg::color_t mem [2][DEPTH]; // Two banks, indexed by bank number
  logic              back_sel;       // Bank the renderer is filling

  // Swap is immediate, tearing on the display is accepted
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      back_sel <= 1'b0;
    end else if (new_frame) begin
      back_sel <= ~back_sel;
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      mem[back_sel][wr_addr] <= wr_color;
    end
  end

  // Front bank read with one cycle of latency
  always_ff @(posedge clk_in) begin
    if (rd_en) begin
      rd_data <= mem[~back_sel][rd_addr];
    end
  end

endmodule

/* fb_read_arbiter.sv */
`timescale 1ns/1ps

module fb_read_arbiter (
  input  logic                 clk_in,
  input  logic                 rst_n,
  input  logic                 scan_req,
  input  pixel_pkg::pix_addr_t scan_addr,
  input  logic                 host_req,
  input  pixel_pkg::pix_addr_t host_addr,
  output logic                 host_gnt,
  output logic                 rd_en,
  output pixel_pkg::pix_addr_t rd_addr
);

  bus_pkg::requester_t last_gnt;

  // Scan-out always wins; the host only gets blanking cycles
  // A host grant is never repeated in the following cycle, so each one is a single pulse
  assign host_gnt = host_req && !scan_req && (last_gnt != bus_pkg::HOST);

  assign rd_en   = scan_req || host_gnt;
  assign rd_addr = scan_req ? scan_addr : host_addr;

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      last_gnt <= bus_pkg::SCAN;
    end else begin
      last_gnt <= host_gnt ? bus_pkg::HOST : bus_pkg::SCAN;
    end
  end

endmodule

/* fb_tb.sv */
`timescale 1ns/1ps

`include "fb_consts.svh"

module fb_tb;

  localparam int FRAME_CLKS    = `H_TOTAL * `V_TOTAL;
  localparam int FRAME_PIXELS  = `DISPLAY_WIDTH * `DISPLAY_HEIGHT;
  localparam int FRAMES_WAITED = 10;
  localparam int APB_ACCESSES  = 150;
  localparam int WATCHDOG_CLKS = (FRAMES_WAITED + 4) * FRAME_CLKS + APB_ACCESSES * (`H_TOTAL + 4);

  logic                   clk_in = 1'b0;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`PADDR_BITS-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  pixel_pkg::color_t      pix_color;
  logic                   pix_active;
  logic                   hsync;
  logic                   vsync;

  int          value_errors = 0;
  int          scan_errors = 0;
  int          check_req = 0;      // Frames requested by the main flow
  int          frames_checked = 0;
  int          pix_cnt = 0;
  bit          checking = 1'b0;
  logic        vsync_q = 1'b1;
  logic [3:0]  exp_offset = '0;
  logic [3:0]  exp_pix;
  logic [31:0] rng = 32'h38ef_e039;

  fb_top u_fb_top (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .pix_color  (pix_color),
    .pix_active (pix_active),
    .hsync      (hsync),
    .vsync      (vsync)
  );

  always #50 clk_in = ~clk_in;

  function automatic logic [3:0] ref_color(int x, int y, logic [3:0] offset);
    return 4'((x + y + int'(offset)) % 16);
  endfunction

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Pixel window: bit 12 set, pixel index y * width + x in bits 11 to 2
  function automatic logic [`PADDR_BITS-1:0] pixel_addr(int x, int y);
    int idx;
    idx = y * `DISPLAY_WIDTH + x;
    return {1'b1, idx[9:0], 2'b00};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic apb_access(input logic write, input logic [`PADDR_BITS-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk_in);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk_in);
    penable = 1'b1;
    while (!pready) begin
      @(negedge clk_in);
    end
    rdata = prdata; // Transfer completes on the next rising edge
    err   = pslverr;
    @(negedge clk_in);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_check(input logic [`PADDR_BITS-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
    logic [31:0] unused;
    logic        err;
    apb_access(1'b1, addr, data, unused, err);
    check_value("pslverr", 32'(err), 32'(exp_err));
  endtask

  task automatic read_check(input logic [`PADDR_BITS-1:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
    logic [31:0] data;
    logic        err;
    apb_access(1'b0, addr, 32'h0, data, err);
    check_value("pslverr", 32'(err), 32'(exp_err));
    if (!exp_err) begin
      check_value("prdata", data, exp_data);
    end
  endtask

  task automatic read_frames(output int n);
    logic [31:0] data;
    logic        err;
    apb_access(1'b0, `REG_FRAMES, 32'h0, data, err);
    n = int'(data[15:0]);
  endtask

  task automatic wait_frames(input int target);
    int n;
    read_frames(n);
    while (n < target) begin
      repeat (`H_TOTAL) @(negedge clk_in);
      read_frames(n);
    end
  endtask

  // The compare process picks up the request at the next vsync fall
  task automatic check_scan_frame(input logic [3:0] offset);
    @(posedge clk_in);
    exp_offset = offset;
    check_req++;
    wait (frames_checked == check_req);
  endtask

  // Position comes from the count of active pixels since vsync fell
  always @(negedge clk_in) begin
    if (rst_n) begin
      if (vsync_q && !vsync) begin
        if (checking) begin
          assert (pix_cnt == FRAME_PIXELS) else begin
            scan_errors++;
            $display("Scanned frame had %0d active pixels instead of %0d", pix_cnt, FRAME_PIXELS);
          end
          frames_checked++;
        end
        checking = (check_req > frames_checked);
        pix_cnt  = 0;
      end
      if (pix_active) begin
        if (checking) begin
          exp_pix = ref_color(pix_cnt % `DISPLAY_WIDTH, pix_cnt / `DISPLAY_WIDTH, exp_offset);
          assert (pix_color === exp_pix) else begin
            scan_errors++;
            $display("error at %0t ns: pix_color = %0h, expected %0h (x %0d, y %0d)", $time,
                     pix_color, exp_pix, pix_cnt % `DISPLAY_WIDTH, pix_cnt / `DISPLAY_WIDTH);
          end
        end
        pix_cnt++;
      end
      vsync_q = vsync;
    end
  end

  initial begin
    repeat (WATCHDOG_CLKS) @(posedge clk_in);
    $display("Timeout: tests still running after %0d clock cycles", WATCHDOG_CLKS);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int         x;
    int         y;
    int         base;
    int         frames_a;
    int         frames_b;
    logic [3:0] pat_p;
    logic [3:0] pat_q;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (16) @(negedge clk_in);
    check_value("hsync", 32'(hsync), 32'd1);
    check_value("vsync", 32'(vsync), 32'd1);
    check_value("pix_active", 32'(pix_active), 32'd0);
    rst_n = 1'b1;
    read_check(`REG_FRAMES, 32'd0, 1'b0);

    rng   = xorshift(rng);
    pat_p = rng[3:0];
    write_check(`REG_PATTERN, {28'h0, pat_p}, 1'b0);
    read_check(`REG_PATTERN, {28'h0, pat_p}, 1'b0);
    read_check(`REG_CTRL, 32'd0, 1'b0);
    read_check(13'h00c, 32'd0, 1'b1);
    write_check(13'h010, 32'h5, 1'b1);
    write_check(pixel_addr(5, 3), 32'h7, 1'b1);

    // Renderer starts with pattern P already in place
    write_check(`REG_CTRL, 32'd1, 1'b0);
    read_check(`REG_CTRL, 32'd1, 1'b0);
    read_frames(base);
    wait_frames(base + 2);
    repeat (16) begin
      rng = xorshift(rng);
      x   = int'(rng[4:0]);
      y   = int'(rng[12:8]) % `DISPLAY_HEIGHT;
      read_check(pixel_addr(x, y), {28'h0, ref_color(x, y, pat_p)}, 1'b0);
    end
    check_scan_frame(pat_p);

    rng   = xorshift(rng);
    pat_q = pat_p + 4'd1 + 4'(rng[2:0]); // Always differs from P
    write_check(`REG_PATTERN, {28'h0, pat_q}, 1'b0);
    read_frames(base);
    wait_frames(base + 2);
    check_scan_frame(pat_q);

    read_frames(frames_a);
    repeat (FRAME_CLKS / 2) @(negedge clk_in);
    read_frames(frames_b);
    assert (frames_b >= frames_a) else begin
      value_errors++;
      $display("Frame counter went down from %0d to %0d", frames_a, frames_b);
    end
    write_check(`REG_CTRL, 32'd0, 1'b0);
    repeat (FRAME_CLKS) @(negedge clk_in);
    read_frames(frames_a);
    repeat (FRAME_CLKS / 2) @(negedge clk_in);
    read_frames(frames_b);
    check_value("prdata", 32'(frames_b), 32'(frames_a)); // Renderer has stopped

    $display("Errors: %0d value, %0d scan-out, %0d bound assertion", value_errors, scan_errors,
             u_fb_top.u_fb_assert.fails);
    if (value_errors + scan_errors + int'(u_fb_top.u_fb_assert.fails) == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* fb_top.sv */
`timescale 1ns/1ps

`include "fb_consts.svh"

module fb_top (
  input  logic                   clk_in,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`PADDR_BITS-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output pixel_pkg::color_t      pix_color,
  output logic                   pix_active,
  output logic                   hsync,
  output logic                   vsync
);

  logic                 enable;
  pixel_pkg::color_t    pattern;
  logic                 wr_en;
  pixel_pkg::pix_addr_t wr_addr;
  pixel_pkg::color_t    wr_color;
  logic                 new_frame;
  logic                 scan_req;
  pixel_pkg::pix_addr_t scan_addr;
  logic                 host_req;
  pixel_pkg::pix_addr_t host_addr;
  logic                 host_gnt;
  logic                 rd_en;
  pixel_pkg::pix_addr_t rd_addr;
  pixel_pkg::color_t    rd_data;   // Shared by scan-out and APB readback

  frame_renderer u_frame_renderer (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .enable    (enable),
    .pattern   (pattern),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_color  (wr_color),
    .new_frame (new_frame)
  );

  fb_manager u_fb_manager (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .new_frame (new_frame),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_color  (wr_color),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  scan_out u_scan_out (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .scan_req   (scan_req),
    .scan_addr  (scan_addr),
    .rd_data    (rd_data),
    .pix_color  (pix_color),
    .pix_active (pix_active),
    .hsync      (hsync),
    .vsync      (vsync)
  );

  fb_read_arbiter u_fb_read_arbiter (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .scan_req  (scan_req),
    .scan_addr (scan_addr),
    .host_req  (host_req),
    .host_addr (host_addr),
    .host_gnt  (host_gnt),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr)
  );

  apb_regs u_apb_regs (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .enable    (enable),
    .pattern   (pattern),
    .new_frame (new_frame),
    .host_req  (host_req),
    .host_addr (host_addr),
    .host_gnt  (host_gnt),
    .rd_data   (rd_data)
  );

endmodule

/* frame_renderer.sv */
`timescale 1ns/1ps

`include "fb_consts.svh"

module frame_renderer (
  input  logic                 clk_in,
  input  logic                 rst_n,
  input  logic                 enable,
  input  pixel_pkg::color_t    pattern,
  output logic                 wr_en,
  output pixel_pkg::pix_addr_t wr_addr,
  output pixel_pkg::color_t    wr_color,
  output logic                 new_frame
);

  pixel_pkg::hcount_t x;
  pixel_pkg::vcount_t y;
  pixel_pkg::color_t  offset;
  logic               running;
  logic               last_col;
  logic               last_pixel;

  assign last_col   = (x == pixel_pkg::hcount_t'(`DISPLAY_WIDTH - 1));
  assign last_pixel = last_col && (y == pixel_pkg::vcount_t'(`DISPLAY_HEIGHT - 1));

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      running   <= 1'b0;
      x         <= '0;
      y         <= '0;
      offset    <= '0;
      wr_en     <= 1'b0;
      new_frame <= 1'b0;
    end else begin
      wr_en     <= running;
      new_frame <= running && last_pixel; // Lands with the write of pixel 767
      if (!running) begin
        running <= enable;
        offset  <= pattern;
      end else if (last_pixel) begin
        // Frame boundary is the only place enable and pattern are sampled
        x       <= '0;
        y       <= '0;
        offset  <= pattern;
        running <= enable;
      end else if (last_col) begin
        x <= '0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  // Colour is (x + y + offset) mod 16, so only the low nibbles matter
  always_ff @(posedge clk_in) begin
    wr_addr  <= pixel_pkg::pix_index(x, y);
    wr_color <= x[3:0] + y[3:0] + offset;
  end

endmodule

/* pixel_pkg.sv */
`include "fb_consts.svh"

package pixel_pkg;

  typedef logic [3:0] color_t;
  typedef logic [`H_BITS-1:0] hcount_t;
  typedef logic [`V_BITS-1:0] vcount_t;
  typedef logic [`ADDR_BITS-1:0] pix_addr_t;

  // Linear pixel index, rows laid out one after another
  function automatic pix_addr_t pix_index(hcount_t x, vcount_t y);
    return pix_addr_t'(y) * pix_addr_t'(`DISPLAY_WIDTH) + pix_addr_t'(x);
  endfunction

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fb_tb -f sim.f -o fb_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/fb_sim +verilator+error+limit+1000 2>&1 | tee sim.log
grep -q "^Simulation passed$" sim.log \
  && echo "Run passed" \
  || { echo "Run failed, see sim.log"; exit 1; }

/* scan_out.sv */
`timescale 1ns/1ps

`include "fb_consts.svh"

module scan_out (
  input  logic                 clk_in,
  input  logic                 rst_n,
  output logic                 scan_req,
  output pixel_pkg::pix_addr_t scan_addr,
  input  pixel_pkg::color_t    rd_data,
  output pixel_pkg::color_t    pix_color,
  output logic                 pix_active,
  output logic                 hsync,
  output logic                 vsync
);

  pixel_pkg::hcount_t h;
  pixel_pkg::vcount_t v;
  logic               active;
  logic               hs;
  logic               vs;
  logic               active_d;
  logic               hs_d;
  logic               vs_d;

  assign active = (h < pixel_pkg::hcount_t'(`DISPLAY_WIDTH)) &&
                  (v < pixel_pkg::vcount_t'(`DISPLAY_HEIGHT));
  assign hs = !((h >= pixel_pkg::hcount_t'(`H_SYNC_START)) &&
                (h <= pixel_pkg::hcount_t'(`H_SYNC_END)));   // Sync is active low
  assign vs = !((v >= pixel_pkg::vcount_t'(`V_SYNC_START)) &&
                (v <= pixel_pkg::vcount_t'(`V_SYNC_END)));

  assign scan_req  = active;
  assign scan_addr = pixel_pkg::pix_index(h, v);

  // Out of reset the raster sits in the last blanking line
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      h <= '0;
      v <= pixel_pkg::vcount_t'(`V_TOTAL - 1);
    end else if (h == pixel_pkg::hcount_t'(`H_TOTAL - 1)) begin
      h <= '0;
      v <= (v == pixel_pkg::vcount_t'(`V_TOTAL - 1)) ? '0 : v + 1'b1;
    end else begin
      h <= h + 1'b1;
    end
  end

  // Two flag stages match the read request plus the registered memory output
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      active_d   <= 1'b0;
      hs_d       <= 1'b1;
      vs_d       <= 1'b1;
      pix_active <= 1'b0;
      hsync      <= 1'b1;
      vsync      <= 1'b1;
    end else begin
      active_d   <= active;
      hs_d       <= hs;
      vs_d       <= vs;
      pix_active <= active_d;
      hsync      <= hs_d;
      vsync      <= vs_d;
    end
  end

  always_ff @(posedge clk_in) begin
    pix_color <= active_d ? rd_data : '0; // Black outside the active area
  end

endmodule

/* sim.f */
+incdir+.
pixel_pkg.sv
bus_pkg.sv
frame_renderer.sv
scan_out.sv
fb_read_arbiter.sv
fb_manager.sv
apb_regs.sv
fb_top.sv
fb_assert.sv
fb_tb.sv
